// File: compile.f
rtl/intExecPkg.sv
rtl/bitCount.sv
rtl/intAluCore.sv
rtl/branchResolve.sv
rtl/intExecCtrl.sv
rtl/intExecUnit.sv
verification/intExecTb.sv

// File: rtl/bitCount.sv
`timescale 1ns/1ns
`default_nettype none

module bitCount import intExecPkg::*; (
    input wire [XLEN_W-1:0] src,
    input wire [1:0] mode,
    output logic [5:0] count
);

    logic [XLEN_W-1:0] scan;
    logic [5:0] lzCount;
    logic [5:0] popCount;

    // reverse for trailing count so one encoder does both
    always_comb begin
        for (int i = 0; i < XLEN_W; i++) begin
            scan[i] = (mode == CNT_TRAIL) ? src[XLEN_W-1-i] : src[i];
        end
    end

    always_comb begin
        lzCount = 6'd32;                 // all zero
        for (int i = 0; i < XLEN_W; i++) begin
            if (scan[i]) lzCount = 6'(XLEN_W - 1 - i);   // highest set bit wins
        end
    end

    always_comb begin
        popCount = '0;
        for (int i = 0; i < XLEN_W; i++) begin
            popCount = popCount + 6'(src[i]);
        end
    end

    assign count = (mode == CNT_POP) ? popCount : lzCount;

endmodule

`default_nettype wire

// File: rtl/branchResolve.sv
`timescale 1ns/1ns
`default_nettype none

module branchResolve import intExecPkg::*; (
    input wire ExecUop_t uop,
    input wire CmpFlags_t cmp,
    input wire Flags_t aluFlags,
    output BranchProv_t redirect,
    output BtUpdate_t btNext,
    output Flags_t uopFlags
);

    logic isBranch;
    logic isIndirect;
    logic branchTaken;
    logic indCorrect;
    logic [XLEN_W-1:0] fallThrough;
    logic [XLEN_W-1:0] branchDst;
    logic [XLEN_W-1:0] indSum;
    logic [XLEN_W-1:0] indDst;
    logic [XLEN_W-1:0] finalHalfwPc;

    always_comb begin
        isBranch = 1'b1;
        case (uop.opcode)
            INT_BEQ: branchTaken = cmp.eq;
            INT_BNE: branchTaken = !cmp.eq;
            INT_BLT: branchTaken = cmp.lt;
            INT_BGE: branchTaken = !cmp.lt;
            INT_BLTU: branchTaken = cmp.ltu;
            INT_BGEU: branchTaken = !cmp.ltu;
            default: begin
                isBranch = 1'b0;
                branchTaken = 1'b0;
            end
        endcase
    end

    assign isIndirect = (uop.opcode == INT_JR) || (uop.opcode == INT_JALR) ||
                        (uop.opcode == INT_RET);

    assign fallThrough = uop.pc + (uop.compressed ? 32'd2 : 32'd4);
    assign branchDst = branchTaken ? uop.pc + {{19{uop.imm[12]}}, uop.imm[12:0]} : fallThrough;

    // ret target is the register alone
    assign indSum = (uop.opcode == INT_RET) ? uop.srcA : uop.srcA + uop.imm;
    assign indDst = {indSum[XLEN_W-1:1], 1'b0};
    assign indCorrect = indDst[XLEN_W-1:1] == uop.srcB[XLEN_W-1:1];  // predicted target in srcB

    // 32-bit ops are only seen once their second halfword is fetched
    assign finalHalfwPc = uop.compressed ? uop.pc : uop.pc + 32'd2;

    //----------------------------------------------------------------------
    // redirect, btb update and commit flags
    //----------------------------------------------------------------------
    always_comb begin
        redirect = '{
            taken: 1'b0,
            dstPC: branchDst,
            sqN: uop.sqN,
            loadSqN: uop.loadSqN,
            storeSqN: uop.storeSqN,
            fetchId: uop.fetchId,
            histAct: HIST_NONE,
            retAct: RET_NONE
        };
        btNext = '{
            valid: 1'b0,
            src: finalHalfwPc,
            dst: branchDst,
            fetchStartOffs: uop.fetchStartOffs,
            multiple: (finalHalfwPc[1 +: FETCH_OFF_W] > uop.fetchPredOffs),
            multipleOffs: FetchOff_t'(uop.fetchPredOffs + 1'b1),
            isJump: 1'b0,
            isCall: 1'b0,
            compressed: uop.compressed
        };
        uopFlags = aluFlags;

        if (isBranch) begin
            if (uop.bpi.predicted) begin
                uopFlags = branchTaken ? FLAGS_PRED_TAKEN : FLAGS_PRED_NTAKEN;
            end else begin
                uopFlags = FLAGS_BRANCH;
            end
            btNext.valid = branchTaken && !uop.bpi.predicted;   // unknown to btb
            if (branchTaken != uop.bpi.taken) begin
                redirect.taken = 1'b1;
                if (uop.bpi.predicted) begin
                    redirect.histAct = branchTaken ? HIST_WRITE_1 : HIST_WRITE_0;
                end else begin
                    redirect.histAct = HIST_APPEND_1;
                end
            end
        end else if (isIndirect && !indCorrect) begin
            redirect.taken = 1'b1;
            redirect.dstPC = indDst;
            if (uop.opcode == INT_RET) redirect.retAct = RET_POP;
            if (uop.opcode == INT_JALR) redirect.retAct = RET_PUSH;
            if (uop.opcode != INT_RET) begin
                btNext.valid = 1'b1;
                btNext.dst = indDst;
                btNext.isJump = 1'b1;
                btNext.isCall = (uop.opcode == INT_JALR);
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/intAluCore.sv
`timescale 1ns/1ns
`default_nettype none

module intAluCore import intExecPkg::*; (
    input wire ExecUop_t uop,
    input wire [5:0] count,
    output logic [1:0] cntMode,
    output logic [XLEN_W-1:0] result,
    output CmpFlags_t cmp,
    output Flags_t aluFlags
);

    logic [XLEN_W-1:0] srcA;
    logic [XLEN_W-1:0] srcB;
    logic [XLEN_W-1:0] imm;
    logic [XLEN_W-1:0] linkAddr;
    logic lessThan;
    logic lessThanU;

    assign srcA = uop.srcA;
    assign srcB = uop.srcB;
    assign imm = uop.imm;

    assign lessThan = $signed(srcA) < $signed(srcB);
    assign lessThanU = srcA < srcB;
    assign cmp = '{eq: (srcA == srcB), lt: lessThan, ltu: lessThanU};

    assign linkAddr = uop.pc + (uop.compressed ? 32'd2 : 32'd4);

    always_comb begin
        case (uop.opcode)
            INT_CTZ: cntMode = CNT_TRAIL;
            INT_CPOP: cntMode = CNT_POP;
            default: cntMode = CNT_LEAD;
        endcase
    end

    //----------------------------------------------------------------------
    // result select
    //----------------------------------------------------------------------
    always_comb begin
        case (uop.opcode)
            INT_AMOADD, INT_ADD: result = srcA + srcB;
            INT_AMOXOR, INT_XOR: result = srcA ^ srcB;
            INT_AMOOR, INT_OR: result = srcA | srcB;
            INT_AMOAND, INT_AND: result = srcA & srcB;
            INT_AMOMIN, INT_MIN: result = lessThan ? srcA : srcB;
            INT_AMOMAX, INT_MAX: result = lessThan ? srcB : srcA;
            INT_AMOMINU, INT_MINU: result = lessThanU ? srcA : srcB;
            INT_AMOMAXU, INT_MAXU: result = lessThanU ? srcB : srcA;
            INT_SUB: result = srcA - srcB;
            INT_SLL: result = srcA << srcB[4:0];
            INT_SRL: result = srcA >> srcB[4:0];
            INT_SRA: result = $signed(srcA) >>> srcB[4:0];
            INT_SLT: result = {{(XLEN_W-1){1'b0}}, lessThan};
            INT_SLTU: result = {{(XLEN_W-1){1'b0}}, lessThanU};
            INT_LUI: result = srcB;            // upper imm comes in on srcB
            INT_AUIPC: result = uop.pc + imm;
            INT_SH1ADD: result = srcB + (srcA << 1);
            INT_SH2ADD: result = srcB + (srcA << 2);
            INT_SH3ADD: result = srcB + (srcA << 3);
            INT_ANDN: result = srcA & ~srcB;
            INT_ORN: result = srcA | ~srcB;
            INT_XNOR: result = ~(srcA ^ srcB);
            INT_SE_B: result = {{24{srcA[7]}}, srcA[7:0]};
            INT_SE_H: result = {{16{srcA[15]}}, srcA[15:0]};
            INT_ZE_H: result = {16'b0, srcA[15:0]};
            INT_CLZ, INT_CTZ, INT_CPOP: result = {{(XLEN_W-6){1'b0}}, count};
            INT_ORC_B: result = {{8{|srcA[31:24]}}, {8{|srcA[23:16]}},
                                 {8{|srcA[15:8]}}, {8{|srcA[7:0]}}};
            INT_REV8: result = {srcA[7:0], srcA[15:8], srcA[23:16], srcA[31:24]};
            INT_JAL, INT_JR, INT_JALR, INT_RET: result = linkAddr;
            default: result = '0;              // sys and branches write nothing useful
        endcase
    end

    // trap code rides in the low imm bits
    assign aluFlags = (uop.opcode == INT_SYS) ? Flags_t'(imm[3:0]) : FLAGS_NONE;

endmodule

`default_nettype wire

// File: rtl/intExecCtrl.sv
`timescale 1ns/1ns
`default_nettype none

module intExecCtrl import intExecPkg::*; (
    input wire clk,
    input wire rst,
    input wire en,
    input wire wbStall,
    input wire invalidate,
    input wire SqN_t invalidateSqN,
    input wire ExecUop_t uop,
    input wire [XLEN_W-1:0] result,
    input wire BranchProv_t redirect,
    input wire BtUpdate_t btNext,
    input wire Flags_t uopFlags,
    output logic wbReq,
    output ZcForward_t zcFwd,
    output ResUop_t resUop,
    output BranchProv_t branch,
    output BtUpdate_t btUpdate,
    output AmoData_t amoData
);

    SqN_t sqDiff;
    logic notFlushed;
    logic accept;
    logic isAmo;

    assign sqDiff = uop.sqN - invalidateSqN;
    assign notFlushed = !invalidate || ($signed(sqDiff) <= 0);   // older or equal survives
    assign accept = uop.valid && en && !wbStall && notFlushed;
    assign isAmo = uop.opcode >= INT_AMOADD;

    // same-cycle paths
    assign wbReq = uop.valid && en;
    assign zcFwd = '{
        valid: uop.valid && en && !uop.tagDst[TAG_W-1],
        tag: uop.tagDst,
        result: result
    };

    //----------------------------------------------------------------------
    // output registers
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        resUop.valid <= 1'b0;
        branch.taken <= 1'b0;
        btUpdate.valid <= 1'b0;
        amoData.valid <= 1'b0;

        if (rst && accept) begin
            resUop <= '{
                valid: 1'b1,
                result: result,
                tagDst: uop.tagDst,
                sqN: uop.sqN,
                flags: uopFlags,
                doNotCommit: 1'b0
            };
            branch <= redirect;
            btUpdate <= btNext;
            amoData <= '{
                valid: isAmo,
                result: result,
                sqN: uop.sqN,
                storeSqN: uop.storeSqN
            };
        end
    end

endmodule

`default_nettype wire

// File: rtl/intExecPkg.sv
`default_nettype none

package intExecPkg;

    localparam int XLEN_W = 32;
    localparam int SQN_W = 7;
    localparam int TAG_W = 7;
    localparam int FETCH_OFF_W = 3;
    localparam int FETCH_ID_W = 5;

    // bitCount mode select
    localparam logic [1:0] CNT_LEAD = 2'd0;
    localparam logic [1:0] CNT_TRAIL = 2'd1;
    localparam logic [1:0] CNT_POP = 2'd2;

    typedef logic [SQN_W-1:0] SqN_t;       // wraps, compare by signed difference
    typedef logic [TAG_W-1:0] Tag_t;       // msb set means no destination
    typedef logic [FETCH_OFF_W-1:0] FetchOff_t;
    typedef logic [FETCH_ID_W-1:0] FetchId_t;

    typedef enum logic [5:0] {
        INT_ADD, INT_SUB, INT_XOR, INT_OR, INT_AND, INT_SLL, INT_SRL, INT_SRA,
        INT_SLT, INT_SLTU, INT_LUI, INT_AUIPC,
        INT_MIN, INT_MAX, INT_MINU, INT_MAXU, INT_SH1ADD, INT_SH2ADD, INT_SH3ADD,
        INT_ANDN, INT_ORN, INT_XNOR,
        INT_SE_B, INT_SE_H, INT_ZE_H, INT_CLZ, INT_CTZ, INT_CPOP, INT_ORC_B,
        INT_REV8, INT_SYS,
        INT_BEQ, INT_BNE, INT_BLT, INT_BGE, INT_BLTU, INT_BGEU,
        INT_JAL, INT_JR, INT_JALR, INT_RET,
        // atomics stay last, decoded by >= INT_AMOADD
        INT_AMOADD, INT_AMOXOR, INT_AMOOR, INT_AMOAND,
        INT_AMOMIN, INT_AMOMAX, INT_AMOMINU, INT_AMOMAXU
    } IntOp_t;

    typedef enum logic [3:0] {
        FLAGS_NONE, FLAGS_BRANCH, FLAGS_PRED_TAKEN, FLAGS_PRED_NTAKEN,
        FLAGS_FENCE, FLAGS_ORDERING, FLAGS_ILLEGAL_INSTR, FLAGS_TRAP,
        FLAGS_BREAK, FLAGS_ECALL, FLAGS_XRET, FLAGS_ACCESS_FAULT,
        FLAGS_PAGE_FAULT, FLAGS_MISALIGNED, FLAGS_INTERRUPT, FLAGS_DEBUG
    } Flags_t;

    typedef enum logic [1:0] {
        HIST_NONE, HIST_APPEND_1, HIST_WRITE_0, HIST_WRITE_1
    } HistAct_t;

    typedef enum logic [1:0] {
        RET_NONE, RET_PUSH, RET_POP
    } RetAct_t;

    typedef struct packed {
        logic predicted;
        logic taken;
    } PredInfo_t;

    typedef struct packed {
        logic eq;
        logic lt;
        logic ltu;
    } CmpFlags_t;

    //----------------------------------------------------------------------
    // uop and output records
    //----------------------------------------------------------------------
    typedef struct packed {
        logic valid;
        logic [XLEN_W-1:0] srcA;
        logic [XLEN_W-1:0] srcB;
        logic [XLEN_W-1:0] imm;
        logic [XLEN_W-1:0] pc;
        IntOp_t opcode;
        Tag_t tagDst;
        SqN_t sqN;
        SqN_t loadSqN;
        SqN_t storeSqN;
        FetchId_t fetchId;
        FetchOff_t fetchStartOffs;
        FetchOff_t fetchPredOffs;
        logic compressed;
        PredInfo_t bpi;
    } ExecUop_t;

    typedef struct packed {
        logic valid;
        logic [XLEN_W-1:0] result;
        Tag_t tagDst;
        SqN_t sqN;
        Flags_t flags;
        logic doNotCommit;
    } ResUop_t;

    typedef struct packed {
        logic taken;                // redirect fetch
        logic [XLEN_W-1:0] dstPC;
        SqN_t sqN;
        SqN_t loadSqN;
        SqN_t storeSqN;
        FetchId_t fetchId;
        HistAct_t histAct;
        RetAct_t retAct;
    } BranchProv_t;

    typedef struct packed {
        logic valid;
        logic [XLEN_W-1:0] src;
        logic [XLEN_W-1:0] dst;
        FetchOff_t fetchStartOffs;
        logic multiple;
        FetchOff_t multipleOffs;
        logic isJump;
        logic isCall;
        logic compressed;
    } BtUpdate_t;

    typedef struct packed {
        logic valid;
        logic [XLEN_W-1:0] result;
        SqN_t sqN;
        SqN_t storeSqN;
    } AmoData_t;

    typedef struct packed {
        logic valid;
        Tag_t tag;
        logic [XLEN_W-1:0] result;
    } ZcForward_t;

endpackage

`default_nettype wire

// File: rtl/intExecUnit.sv
`timescale 1ns/1ns
`default_nettype none

module intExecUnit import intExecPkg::*; (
    input wire clk,
    input wire rst,
    input wire en,
    input wire wbStall,
    input wire ExecUop_t uop,
    input wire invalidate,
    input wire SqN_t invalidateSqN,
    output logic wbReq,
    output ZcForward_t zcFwd,
    output ResUop_t resUop,
    output BranchProv_t branch,
    output BtUpdate_t btUpdate,
    output AmoData_t amoData
);

    logic [5:0] count;
    logic [1:0] cntMode;
    logic [XLEN_W-1:0] result;
    CmpFlags_t cmp;
    Flags_t aluFlags;
    BranchProv_t redirect;
    BtUpdate_t btNext;
    Flags_t uopFlags;

    bitCount bitCountI (
        .src(uop.srcA),
        .mode(cntMode),
        .count(count)
    );

    intAluCore aluI (
        .uop(uop),
        .count(count),
        .cntMode(cntMode),
        .result(result),
        .cmp(cmp),
        .aluFlags(aluFlags)
    );

    branchResolve branchI (
        .uop(uop),
        .cmp(cmp),
        .aluFlags(aluFlags),
        .redirect(redirect),
        .btNext(btNext),
        .uopFlags(uopFlags)
    );

    intExecCtrl ctrlI (
        .clk(clk),
        .rst(rst),
        .en(en),
        .wbStall(wbStall),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .uop(uop),
        .result(result),
        .redirect(redirect),
        .btNext(btNext),
        .uopFlags(uopFlags),
        .wbReq(wbReq),
        .zcFwd(zcFwd),
        .resUop(resUop),
        .branch(branch),
        .btUpdate(btUpdate),
        .amoData(amoData)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the integer execute unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module intExecTb -o intExecSim -f compile.f

./obj_dir/intExecSim > sim.log 2>&1 || true
cat sim.log

grep -q "PASS: all tests" sim.log

// File: verification/intExecTb.sv
`timescale 1ns/1ns
`default_nettype none

module intExecTb import intExecPkg::*; ();

    typedef struct packed {
        ResUop_t res;
        BranchProv_t br;
        BtUpdate_t bt;
        AmoData_t amo;
    } Expect_t;

    logic clk;
    logic rst;
    logic en;
    logic wbStall;
    logic invalidate;
    SqN_t invalidateSqN;
    ExecUop_t uop;
    logic wbReq;
    ZcForward_t zcFwd;
    ResUop_t resUop;
    BranchProv_t branch;
    BtUpdate_t btUpdate;
    AmoData_t amoData;

    Expect_t pend = '0;   // outputs due at the next check
    int checks = 0;
    int errors = 0;

    intExecUnit dut (
        .clk(clk),
        .rst(rst),
        .en(en),
        .wbStall(wbStall),
        .uop(uop),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .wbReq(wbReq),
        .zcFwd(zcFwd),
        .resUop(resUop),
        .branch(branch),
        .btUpdate(btUpdate),
        .amoData(amoData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //---------------------------------------------------------------------
    // reference model
    //---------------------------------------------------------------------
    function automatic logic [31:0] countLeading(logic [31:0] v);
        int n;
        n = 0;
        while (n < 32 && !v[31-n]) n++;
        return 32'(n);
    endfunction

    function automatic logic [31:0] countTrailing(logic [31:0] v);
        int n;
        n = 0;
        while (n < 32 && !v[n]) n++;
        return 32'(n);
    endfunction

    function automatic logic [31:0] countOnes(logic [31:0] v);
        int n;
        n = 0;
        for (int i = 0; i < 32; i++) n += int'(v[i]);
        return 32'(n);
    endfunction

    function automatic logic [31:0] aluModel(ExecUop_t u);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic sLess;
        logic uLess;
        a = u.srcA;
        b = u.srcB;
        sLess = $signed(a) < $signed(b);
        uLess = a < b;
        r = '0;
        case (u.opcode)
            INT_ADD, INT_AMOADD: r = a + b;
            INT_XOR, INT_AMOXOR: r = a ^ b;
            INT_OR, INT_AMOOR: r = a | b;
            INT_AND, INT_AMOAND: r = a & b;
            INT_MIN, INT_AMOMIN: r = sLess ? a : b;
            INT_MAX, INT_AMOMAX: r = sLess ? b : a;
            INT_MINU, INT_AMOMINU: r = uLess ? a : b;
            INT_MAXU, INT_AMOMAXU: r = uLess ? b : a;
            INT_SUB: r = a - b;
            INT_SLL: r = a << b[4:0];
            INT_SRL: r = a >> b[4:0];
            INT_SRA: r = 32'($signed(a) >>> b[4:0]);
            INT_SLT: r = {31'b0, sLess};
            INT_SLTU: r = {31'b0, uLess};
            INT_LUI: r = b;
            INT_AUIPC: r = u.pc + u.imm;
            INT_SH1ADD: r = (a << 1) + b;
            INT_SH2ADD: r = (a << 2) + b;
            INT_SH3ADD: r = (a << 3) + b;
            INT_ANDN: r = a & ~b;
            INT_ORN: r = a | ~b;
            INT_XNOR: r = ~(a ^ b);
            INT_SE_B: r = 32'($signed(a[7:0]));
            INT_SE_H: r = 32'($signed(a[15:0]));
            INT_ZE_H: r = {16'b0, a[15:0]};
            INT_CLZ: r = countLeading(a);
            INT_CTZ: r = countTrailing(a);
            INT_CPOP: r = countOnes(a);
            INT_ORC_B: begin
                for (int i = 0; i < 4; i++) r[8*i +: 8] = (a[8*i +: 8] != 8'h0) ? 8'hff : 8'h00;
            end
            INT_REV8: begin
                for (int i = 0; i < 4; i++) r[8*i +: 8] = a[8*(3-i) +: 8];
            end
            INT_JAL, INT_JR, INT_JALR, INT_RET: r = u.pc + (u.compressed ? 32'd2 : 32'd4);
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic logic condTaken(ExecUop_t u);
        case (u.opcode)
            INT_BEQ: return u.srcA == u.srcB;
            INT_BNE: return u.srcA != u.srcB;
            INT_BLT: return $signed(u.srcA) < $signed(u.srcB);
            INT_BGE: return $signed(u.srcA) >= $signed(u.srcB);
            INT_BLTU: return u.srcA < u.srcB;
            INT_BGEU: return u.srcA >= u.srcB;
            default: return 1'b0;
        endcase
    endfunction

    function automatic Expect_t modelUop(ExecUop_t u);
        Expect_t e;
        logic isCond;
        logic tk;
        logic [31:0] target;
        e = '0;
        isCond = (u.opcode >= INT_BEQ) && (u.opcode <= INT_BGEU);
        tk = condTaken(u);
        e.res = '{valid: 1'b1, result: aluModel(u), tagDst: u.tagDst, sqN: u.sqN,
                  flags: FLAGS_NONE, doNotCommit: 1'b0};
        if (u.opcode == INT_SYS) e.res.flags = Flags_t'(u.imm[3:0]);
        e.br.sqN = u.sqN;
        e.br.loadSqN = u.loadSqN;
        e.br.storeSqN = u.storeSqN;
        e.br.fetchId = u.fetchId;
        e.bt.src = u.compressed ? u.pc : u.pc + 32'd2;   // last halfword of the op
        e.bt.fetchStartOffs = u.fetchStartOffs;
        e.bt.compressed = u.compressed;
        // last halfword sits past the predicted slot of the fetch block
        e.bt.multiple = e.bt.src[3:1] > u.fetchPredOffs;
        e.bt.multipleOffs = u.fetchPredOffs + 3'd1;
        if (isCond) begin
            target = tk ? u.pc + {{19{u.imm[12]}}, u.imm[12:0]}
                        : u.pc + (u.compressed ? 32'd2 : 32'd4);
            if (u.bpi.predicted) e.res.flags = tk ? FLAGS_PRED_TAKEN : FLAGS_PRED_NTAKEN;
            else e.res.flags = FLAGS_BRANCH;
            e.br.taken = tk != u.bpi.taken;
            e.br.dstPC = target;
            if (u.bpi.predicted) e.br.histAct = tk ? HIST_WRITE_1 : HIST_WRITE_0;
            else e.br.histAct = HIST_APPEND_1;
            e.bt.valid = tk && !u.bpi.predicted;
            e.bt.dst = target;
        end else if (u.opcode == INT_JR || u.opcode == INT_JALR || u.opcode == INT_RET) begin
            target = (u.opcode == INT_RET) ? u.srcA : u.srcA + u.imm;
            target[0] = 1'b0;
            if (target[31:1] != u.srcB[31:1]) begin
                e.br.taken = 1'b1;
                e.br.dstPC = target;
                if (u.opcode == INT_RET) e.br.retAct = RET_POP;
                if (u.opcode == INT_JALR) e.br.retAct = RET_PUSH;
                e.bt.valid = u.opcode != INT_RET;
                e.bt.dst = target;
                e.bt.isJump = 1'b1;
                e.bt.isCall = u.opcode == INT_JALR;
            end
        end
        e.amo = '{valid: u.opcode >= INT_AMOADD, result: e.res.result, sqN: u.sqN,
                  storeSqN: u.storeSqN};
        return e;
    endfunction

    //---------------------------------------------------------------------
    // checking
    //---------------------------------------------------------------------
    task automatic checkBit(string name, logic expV, logic actV);
        checks++;
        assert (expV === actV) else begin
            errors++;
            $display("error at %0t ns: %s expected %b actual %b", $time, name, expV, actV);
        end
    endtask

    task automatic checkWord(string name, logic [31:0] expV, logic [31:0] actV);
        checks++;
        assert (expV === actV) else begin
            errors++;
            $display("error at %0t ns: %s expected %h actual %h", $time, name, expV, actV);
        end
    endtask

    // outputs are stable at the falling edge
    task automatic checkCycle();
        Expect_t nxt;
        SqN_t sqAge;
        logic zv;
        logic acc;
        checkBit("resUop.valid", pend.res.valid, resUop.valid);
        checkBit("branch.taken", pend.br.taken, branch.taken);
        checkBit("btUpdate.valid", pend.bt.valid, btUpdate.valid);
        checkBit("amoData.valid", pend.amo.valid, amoData.valid);
        if (pend.res.valid) begin
            checkWord("resUop.result", pend.res.result, resUop.result);
            checkWord("resUop.tagDst", 32'(pend.res.tagDst), 32'(resUop.tagDst));
            checkWord("resUop.sqN", 32'(pend.res.sqN), 32'(resUop.sqN));
            checkWord("resUop.flags", 32'(pend.res.flags), 32'(resUop.flags));
            checkBit("resUop.doNotCommit", 1'b0, resUop.doNotCommit);
        end
        if (pend.br.taken) begin
            checkWord("branch.dstPC", pend.br.dstPC, branch.dstPC);
            checkWord("branch.sqN", 32'(pend.br.sqN), 32'(branch.sqN));
            checkWord("branch.loadSqN", 32'(pend.br.loadSqN), 32'(branch.loadSqN));
            checkWord("branch.storeSqN", 32'(pend.br.storeSqN), 32'(branch.storeSqN));
            checkWord("branch.fetchId", 32'(pend.br.fetchId), 32'(branch.fetchId));
            checkWord("branch.histAct", 32'(pend.br.histAct), 32'(branch.histAct));
            checkWord("branch.retAct", 32'(pend.br.retAct), 32'(branch.retAct));
        end
        if (pend.bt.valid) begin
            checkWord("btUpdate.src", pend.bt.src, btUpdate.src);
            checkWord("btUpdate.dst", pend.bt.dst, btUpdate.dst);
            checkWord("btUpdate.fetchStartOffs", 32'(pend.bt.fetchStartOffs),
                      32'(btUpdate.fetchStartOffs));
            checkBit("btUpdate.multiple", pend.bt.multiple, btUpdate.multiple);
            checkWord("btUpdate.multipleOffs", 32'(pend.bt.multipleOffs),
                      32'(btUpdate.multipleOffs));
            checkBit("btUpdate.isJump", pend.bt.isJump, btUpdate.isJump);
            checkBit("btUpdate.isCall", pend.bt.isCall, btUpdate.isCall);
            checkBit("btUpdate.compressed", pend.bt.compressed, btUpdate.compressed);
        end
        if (pend.amo.valid) begin
            checkWord("amoData.result", pend.amo.result, amoData.result);
            checkWord("amoData.sqN", 32'(pend.amo.sqN), 32'(amoData.sqN));
            checkWord("amoData.storeSqN", 32'(pend.amo.storeSqN), 32'(amoData.storeSqN));
        end

        // same-cycle outputs
        nxt = modelUop(uop);
        zv = uop.valid && en && !uop.tagDst[6];
        checkBit("wbReq", uop.valid && en, wbReq);
        checkBit("zcFwd.valid", zv, zcFwd.valid);
        if (zv) begin
            checkWord("zcFwd.tag", 32'(uop.tagDst), 32'(zcFwd.tag));
            checkWord("zcFwd.result", nxt.res.result, zcFwd.result);
        end

        sqAge = uop.sqN - invalidateSqN;
        acc = rst && uop.valid && en && !wbStall &&
              (!invalidate || sqAge[6] || sqAge == '0);   // older or same survives
        if (!acc) begin
            nxt.res.valid = 1'b0;
            nxt.br.taken = 1'b0;
            nxt.bt.valid = 1'b0;
            nxt.amo.valid = 1'b0;
        end
        pend = nxt;
    endtask

    always @(negedge clk) checkCycle();

    //---------------------------------------------------------------------
    // stimulus
    //---------------------------------------------------------------------
    function automatic logic [31:0] edgeOrRandom();
        case ($urandom % 6)
            0: return 32'h0;
            1: return 32'hffff_ffff;
            2: return 32'h8000_0000;
            default: return $urandom;
        endcase
    endfunction

    function automatic ExecUop_t randomUop(IntOp_t op);
        ExecUop_t u;
        u.valid = 1'b1;
        u.srcA = edgeOrRandom();
        u.srcB = edgeOrRandom();
        u.imm = $urandom;
        u.pc = $urandom & 32'hffff_fffe;
        u.opcode = op;
        u.tagDst = Tag_t'($urandom);
        u.sqN = SqN_t'($urandom);
        u.loadSqN = SqN_t'($urandom);
        u.storeSqN = SqN_t'($urandom);
        u.fetchId = FetchId_t'($urandom);
        u.fetchStartOffs = FetchOff_t'($urandom);
        u.fetchPredOffs = FetchOff_t'($urandom);
        u.compressed = 1'($urandom);
        u.bpi = PredInfo_t'(2'($urandom));
        return u;
    endfunction

    task automatic issue(ExecUop_t u, logic enV, logic stallV, logic invV, SqN_t invSqN);
        @(posedge clk);
        uop <= u;
        en <= enV;
        wbStall <= stallV;
        invalidate <= invV;
        invalidateSqN <= invSqN;
    endtask

    function automatic IntOp_t plainOp();
        return IntOp_t'(6'($urandom % 31));   // ADD up to SYS
    endfunction

    initial begin
        ExecUop_t u;
        IntOp_t op;
        int timeout;
        logic drained;
        void'($urandom(32'hcc71));
        rst = 1'b0;
        en = 1'b0;
        wbStall = 1'b0;
        invalidate = 1'b0;
        invalidateSqN = '0;
        uop = '0;

        // live uops during reset must not come out
        repeat (3) issue(randomUop(plainOp()), 1'b1, 1'b0, 1'b0, '0);
        rst <= 1'b1;

        for (int i = 0; i < 300; i++) issue(randomUop(plainOp()), 1'b1, 1'b0, 1'b0, '0);

        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 4; p++) begin
                repeat (6) begin
                    u = randomUop(IntOp_t'(6'(int'(INT_BEQ) + k)));
                    u.bpi = PredInfo_t'(2'(p));
                    if ($urandom % 3 == 0) u.srcB = u.srcA;
                    issue(u, 1'b1, 1'b0, 1'b0, '0);
                end
            end
        end

        // indirect jumps, half with a correct target in srcB
        for (int i = 0; i < 80; i++) begin
            case ($urandom % 4)
                0: op = INT_JR;
                1: op = INT_JALR;
                2: op = INT_RET;
                default: op = INT_JAL;
            endcase
            u = randomUop(op);
            if ($urandom % 2 == 0) begin
                u.srcB = (op == INT_RET) ? u.srcA : u.srcA + u.imm;
                u.srcB[0] = 1'($urandom);
            end
            issue(u, 1'b1, 1'b0, 1'b0, '0);
        end

        for (int i = 0; i < 80; i++) begin
            if ($urandom % 2 == 0) op = IntOp_t'(6'(int'(INT_AMOADD) + int'($urandom % 8)));
            else op = plainOp();
            issue(randomUop(op), 1'b1, 1'b0, 1'b0, '0);
        end

        // acceptance under enable, stall and invalidation
        u = randomUop(INT_ADD);
        issue(u, 1'b1, 1'b0, 1'b1, u.sqN + 7'd3);
        u = randomUop(INT_SUB);
        issue(u, 1'b1, 1'b0, 1'b1, u.sqN);
        u = randomUop(INT_XOR);
        issue(u, 1'b1, 1'b0, 1'b1, u.sqN - 7'd3);
        for (int i = 0; i < 250; i++) begin
            u = randomUop(IntOp_t'(6'($urandom % 49)));
            u.valid = ($urandom % 5) != 0;
            issue(u, ($urandom % 4) != 0, ($urandom % 4) == 0, 1'($urandom),
                  SqN_t'($urandom));
        end
        issue('0, 1'b1, 1'b0, 1'b0, '0);

        timeout = 0;
        drained = 1'b0;
        while (!drained && timeout < 10) begin
            @(negedge clk);
            drained = !(resUop.valid || branch.taken || btUpdate.valid || amoData.valid);
            timeout++;
        end
        if (!drained) begin
            errors++;
            $display("timeout: outputs stayed valid after the input went idle");
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
